//--- codec/codec_tdm.sv
// --------------------------------------------------------------------------
// TDM serial port for the codec. Generates bick and lrck from clk, captures
// the four ADC slots into adc_quad and shifts dac_quad out on sdin1, one
// frame of four 32-bit slots every FRAME_CLKS cycles.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module codec_tdm #(
    parameter int SAMPLE_W = pmod_pkg::SAMPLE_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   bick,
    output logic                   lrck,
    output logic                   sdin1,
    input  logic                   sdout1,
    output logic                   frame_strobe,
    output pmod_pkg::sample_quad_t adc_quad,
    input  pmod_pkg::sample_quad_t dac_quad
);
    import pmod_pkg::*;

    localparam int CNT_W   = $clog2(FRAME_CLKS);
    localparam int BIT_W   = $clog2(SLOT_BITS);
    localparam int FRAME_W = 4 * SLOT_BITS;
    localparam int PAD_W   = SLOT_BITS - SAMPLE_W;

    logic [CNT_W-1:0]    cnt;
    logic [CNT_W-1:0]    cnt_nxt;
    logic [BIT_W-1:0]    bit_idx;
    logic [1:0]          slot;
    logic                bick_rise;
    logic [SAMPLE_W-1:0] rx_sr;
    logic [SAMPLE_W-1:0] rx_word;
    logic [FRAME_W-1:0]  tx_sr;
    logic [FRAME_W-1:0]  tx_frame;

    // Two clk cycles per bit, so bit index and slot sit above cnt[0]
    assign cnt_nxt   = cnt + 1'b1;
    assign bit_idx   = cnt[BIT_W:1];
    assign slot      = cnt[CNT_W-1 -: 2];
    assign bick_rise = ~cnt[0];
    assign frame_strobe = (cnt == CNT_W'(FRAME_CLKS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            bick <= 1'b0;
            lrck <= 1'b0;
        end else begin
            cnt  <= cnt_nxt;
            bick <= cnt_nxt[0];
            // Slots 0 and 1 form the high half of lrck
            lrck <= ~cnt_nxt[CNT_W-1];
        end
    end

    // Receive side is sampled on the bick rising edge
    assign rx_word = {rx_sr[SAMPLE_W-2:0], sdout1};

    always_ff @(posedge clk) begin
        if (bick_rise && (bit_idx < SAMPLE_W)) begin
            rx_sr <= rx_word;
        end
        // Low bits of each slot are padding and are dropped
        if (bick_rise && (bit_idx == BIT_W'(SAMPLE_W - 1))) begin
            adc_quad[(3 - slot)*SAMPLE_W +: SAMPLE_W] <= rx_word;
        end
    end

    // Left-justified samples with zero padding
    assign tx_frame = {dac_quad.ch0, {PAD_W{1'b0}},
                       dac_quad.ch1, {PAD_W{1'b0}},
                       dac_quad.ch2, {PAD_W{1'b0}},
                       dac_quad.ch3, {PAD_W{1'b0}}};

    // Transmit side moves on the bick falling edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_sr <= '0;
        end else if (frame_strobe) begin
            tx_sr <= tx_frame;
        end else if (cnt[0]) begin
            tx_sr <= {tx_sr[FRAME_W-2:0], 1'b0};
        end
    end

    assign sdin1 = tx_sr[FRAME_W-1];

endmodule

//--- common/pmod_pkg.sv
// --------------------------------------------------------------------------
// Common definitions for the four-channel codec subsystem. Holds the sample
// types, the Wishbone request and response structs, the calibration and
// control word layouts and the register map. Every RTL block imports it.
// --------------------------------------------------------------------------
package pmod_pkg;

    localparam int SAMPLE_W = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Channel 0 occupies the top bits
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
    } sample_quad_t;

    // Gain is unsigned Q2.14, offset is subtracted before the gain
    typedef struct packed {
        logic [15:0] gain;
        sample_t     offset;
    } cal_entry_t;

    typedef enum logic [1:0] {
        CORE_MIRROR   = 2'd0,
        CORE_VCA      = 2'd1,
        CORE_BITCRUSH = 2'd2,
        CORE_MUTE     = 2'd3
    } core_sel_e;

    typedef struct packed {
        logic [25:0] reserved;
        logic [3:0]  crush_bits;
        core_sel_e   core_sel;
    } ctrl_word_t;

    // One bus data word, read as a cal entry or as the control word
    typedef union packed {
        logic [31:0] raw;
        cal_entry_t  cal;
        ctrl_word_t  ctrl;
    } reg_word_u;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Register map and frame geometry
    localparam logic [3:0]  REG_CAL_BASE = 4'd0;
    localparam logic [3:0]  REG_CTRL     = 4'd8;
    localparam logic [15:0] CAL_ONE      = 16'h4000;
    localparam int          SLOT_BITS    = 32;
    localparam int          FRAME_CLKS   = 256;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pmod -f tb.f \
    -o tb_pmod_sim \
    && ./obj_dir/tb_pmod_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation finished: PASS" sim.log && echo "run_sim: passed" && exit 0 \
    || { echo "run_sim: failed"; exit 1; }

//--- source/dsp_core.sv
// --------------------------------------------------------------------------
// Per-frame processing of the four calibrated channels. core_ctrl picks
// mirror, VCA, bitcrush or mute, and the result is registered on the
// core_start pulse from the sequencer.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module dsp_core #(
    parameter int SAMPLE_W = pmod_pkg::SAMPLE_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   core_start,
    input  pmod_pkg::sample_quad_t core_in,
    input  pmod_pkg::ctrl_word_t   core_ctrl,
    output pmod_pkg::sample_quad_t core_out
);
    import pmod_pkg::*;

    sample_quad_t        result;
    logic [SAMPLE_W-1:0] crush_mask;

    // Full scale on the level channel is close to unity gain
    function automatic sample_t vca_scale(sample_t x, sample_t level);
        logic signed [2*SAMPLE_W-1:0] prod;
        prod = x * level;
        return prod[2*SAMPLE_W-2 -: SAMPLE_W];
    endfunction

    assign crush_mask = {SAMPLE_W{1'b1}} << core_ctrl.crush_bits;

    always_comb begin
        case (core_ctrl.core_sel)
            CORE_MIRROR: begin
                result = core_in;
            end
            CORE_VCA: begin
                // Channel 3 is the control voltage
                result.ch0 = vca_scale(core_in.ch0, core_in.ch3);
                result.ch1 = vca_scale(core_in.ch1, core_in.ch3);
                result.ch2 = vca_scale(core_in.ch2, core_in.ch3);
                result.ch3 = core_in.ch3;
            end
            CORE_BITCRUSH: begin
                result.ch0 = core_in.ch0 & crush_mask;
                result.ch1 = core_in.ch1 & crush_mask;
                result.ch2 = core_in.ch2 & crush_mask;
                result.ch3 = core_in.ch3 & crush_mask;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_out <= '0;
        end else if (core_start) begin
            core_out <= result;
        end
    end

endmodule

//--- source/pmod_ctrl.sv
// --------------------------------------------------------------------------
// Control block. Serves the Wishbone register file of eight cal entries and
// the control word, and runs the per-frame sequence that steers samples
// through sample_cal and dsp_core into the next DAC frame.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module pmod_ctrl #(
    parameter int SAMPLE_W = pmod_pkg::SAMPLE_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pmod_pkg::wb_req_t      wb_req,
    output pmod_pkg::wb_rsp_t      wb_rsp,
    input  logic                   frame_strobe,
    input  pmod_pkg::sample_quad_t adc_quad,
    output pmod_pkg::sample_t      cal_in,
    output pmod_pkg::cal_entry_t   cal_entry,
    output logic                   cal_issue,
    input  pmod_pkg::sample_t      cal_out,
    input  logic                   cal_valid,
    output pmod_pkg::sample_quad_t core_in,
    output pmod_pkg::ctrl_word_t   core_ctrl,
    output logic                   core_start,
    input  pmod_pkg::sample_quad_t core_out,
    output pmod_pkg::sample_quad_t dac_quad
);
    import pmod_pkg::*;

    localparam int NUM_ENTRIES = 8;

    cal_entry_t          cal_regs [NUM_ENTRIES];
    cal_entry_t          cal_act  [NUM_ENTRIES];
    ctrl_word_t          ctrl_reg;
    ctrl_word_t          ctrl_act;
    reg_word_u           wr_word;
    reg_word_u           rd_word;
    logic                bus_req;
    logic                is_cal;
    logic [2:0]          cal_idx;
    logic [3:0]          phase;
    logic                ph_in;
    logic                ph_out;
    logic [1:0]          iss_ch;
    logic [1:0]          ret_ch;
    logic [SAMPLE_W-1:0] adc_sel;

    // A new access is taken once, ack then blocks it for a cycle
    assign bus_req = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
    assign is_cal  = (wb_req.adr < REG_CTRL);
    assign cal_idx = 3'(wb_req.adr - REG_CAL_BASE);
    assign wr_word.raw = wb_req.dat;

    always_comb begin
        rd_word.raw = '0;
        if (is_cal) begin
            rd_word.cal = cal_regs[cal_idx];
        end else if (wb_req.adr == REG_CTRL) begin
            rd_word.ctrl = ctrl_reg;
        end
    end

    // Active copies are taken at frame_strobe so a frame never mixes settings
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                cal_regs[i] <= '{gain: CAL_ONE, offset: '0};
                cal_act[i]  <= '{gain: CAL_ONE, offset: '0};
            end
            ctrl_reg          <= '0;
            ctrl_reg.core_sel <= CORE_MIRROR;
            ctrl_act          <= '0;
            ctrl_act.core_sel <= CORE_MIRROR;
        end else begin
            if (bus_req && wb_req.we) begin
                if (is_cal) begin
                    cal_regs[cal_idx] <= wr_word.cal;
                end else if (wb_req.adr == REG_CTRL) begin
                    ctrl_reg <= wr_word.ctrl;
                end
            end
            if (frame_strobe) begin
                cal_act  <= cal_regs;
                ctrl_act <= ctrl_reg;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= bus_req;
            if (bus_req) begin
                wb_rsp.dat <= rd_word.raw;
            end
        end
    end

    // Phase 1 follows frame_strobe and the sequence ends at phase 13
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (frame_strobe) begin
            phase <= 4'd1;
        end else if (phase == 4'd13) begin
            phase <= '0;
        end else if (phase != '0) begin
            phase <= phase + 4'd1;
        end
    end

    // Phases 1-4 issue ADC samples, phases 8-11 issue core results
    assign ph_in     = (phase >= 4'd1) && (phase <= 4'd4);
    assign ph_out    = (phase >= 4'd8) && (phase <= 4'd11);
    assign cal_issue = ph_in | ph_out;
    assign iss_ch    = ph_in ? 2'(phase - 4'd1) : phase[1:0];

    // Front end inverts the inputs
    assign adc_sel   = adc_quad[(3 - iss_ch)*SAMPLE_W +: SAMPLE_W];
    assign cal_in    = ph_in ? ~adc_sel : core_out[(3 - iss_ch)*SAMPLE_W +: SAMPLE_W];
    assign cal_entry = cal_act[{ph_out, iss_ch}];

    assign core_start = (phase == 4'd7);
    assign core_ctrl  = ctrl_act;

    // Results return two cycles after issue
    assign ret_ch = (phase <= 4'd6) ? 2'(phase - 4'd3) : 2'(phase - 4'd10);

    always_ff @(posedge clk) begin
        if (cal_valid && (phase <= 4'd6)) begin
            core_in[(3 - ret_ch)*SAMPLE_W +: SAMPLE_W] <= cal_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dac_quad <= '0;
        end else if (cal_valid && (phase >= 4'd10)) begin
            dac_quad[(3 - ret_ch)*SAMPLE_W +: SAMPLE_W] <= cal_out;
        end
    end

endmodule

//--- source/pmod_top.sv
// --------------------------------------------------------------------------
// Top level of the codec subsystem. Ties the TDM port, the control block,
// the calibration pipeline and the DSP core together. The codec pins and
// the Wishbone slave are the only external interfaces.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module pmod_top #(
    parameter int SAMPLE_W = pmod_pkg::SAMPLE_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  pmod_pkg::wb_req_t wb_req,
    output pmod_pkg::wb_rsp_t wb_rsp,
    output logic              bick,
    output logic              lrck,
    output logic              sdin1,
    input  logic              sdout1
);
    import pmod_pkg::*;

    logic         frame_strobe;
    sample_quad_t adc_quad;
    sample_quad_t dac_quad;
    sample_t      cal_in;
    cal_entry_t   cal_entry;
    logic         cal_issue;
    sample_t      cal_out;
    logic         cal_valid;
    sample_quad_t core_in;
    ctrl_word_t   core_ctrl;
    logic         core_start;
    sample_quad_t core_out;

    codec_tdm #(
        .SAMPLE_W (SAMPLE_W)
    ) codec_tdm_instance (
        .clk          (clk),
        .rst_n        (rst_n),
        .bick         (bick),
        .lrck         (lrck),
        .sdin1        (sdin1),
        .sdout1       (sdout1),
        .frame_strobe (frame_strobe),
        .adc_quad     (adc_quad),
        .dac_quad     (dac_quad)
    );

    pmod_ctrl #(
        .SAMPLE_W (SAMPLE_W)
    ) pmod_ctrl_instance (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .frame_strobe (frame_strobe),
        .adc_quad     (adc_quad),
        .cal_in       (cal_in),
        .cal_entry    (cal_entry),
        .cal_issue    (cal_issue),
        .cal_out      (cal_out),
        .cal_valid    (cal_valid),
        .core_in      (core_in),
        .core_ctrl    (core_ctrl),
        .core_start   (core_start),
        .core_out     (core_out),
        .dac_quad     (dac_quad)
    );

    // One pipeline serves both the input and output calibration
    sample_cal #(
        .SAMPLE_W (SAMPLE_W)
    ) sample_cal_instance (
        .clk       (clk),
        .rst_n     (rst_n),
        .cal_issue (cal_issue),
        .cal_in    (cal_in),
        .cal_entry (cal_entry),
        .cal_out   (cal_out),
        .cal_valid (cal_valid)
    );

    dsp_core #(
        .SAMPLE_W (SAMPLE_W)
    ) dsp_core_instance (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_start (core_start),
        .core_in    (core_in),
        .core_ctrl  (core_ctrl),
        .core_out   (core_out)
    );

endmodule

//--- source/sample_cal.sv
// --------------------------------------------------------------------------
// Calibration pipeline shared by the ADC and DAC paths. Takes one sample
// and one cal entry per cycle and returns the result two cycles later as
// saturate((sample - offset) * gain >>> 14), flagged by cal_valid.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module sample_cal #(
    parameter int SAMPLE_W = pmod_pkg::SAMPLE_W
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cal_issue,
    input  pmod_pkg::sample_t    cal_in,
    input  pmod_pkg::cal_entry_t cal_entry,
    output pmod_pkg::sample_t    cal_out,
    output logic                 cal_valid
);
    import pmod_pkg::*;

    localparam int GAIN_W  = 16;
    localparam int FRAC_W  = 14;
    localparam int PROD_W  = SAMPLE_W + GAIN_W + 2;
    localparam int SAT_MAX = 2**(SAMPLE_W-1) - 1;
    localparam int SAT_MIN = -(2**(SAMPLE_W-1));

    logic signed [SAMPLE_W:0] diff_d;
    logic signed [SAMPLE_W:0] diff_q;
    logic [GAIN_W-1:0]        gain_q;
    logic                     valid_q;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] scaled;
    sample_t                  sat_d;

    // One extra bit keeps the stage 1 difference exact
    assign diff_d = $signed(cal_in) - $signed(cal_entry.offset);

    // Gain is unsigned and gets a zero sign bit for the stage 2 product
    assign prod   = diff_q * $signed({1'b0, gain_q});
    assign scaled = prod >>> FRAC_W;

    always_comb begin
        if (scaled > SAT_MAX) begin
            sat_d = sample_t'(SAT_MAX);
        end else if (scaled < SAT_MIN) begin
            sat_d = sample_t'(SAT_MIN);
        end else begin
            sat_d = scaled[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            cal_valid <= 1'b0;
        end else begin
            valid_q   <= cal_issue;
            cal_valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        diff_q  <= diff_d;
        gain_q  <= cal_entry.gain;
        cal_out <= sat_d;
    end

endmodule

//--- tb.f
common/pmod_pkg.sv
codec/codec_tdm.sv
source/sample_cal.sv
source/dsp_core.sv
source/pmod_ctrl.sv
source/pmod_top.sv
test/pmod_asserts.sv
test/pmod_checker.sv
test/tb_pmod.sv

//--- test/pmod_asserts.sv
// ---------------------------------------------------------------------------
// Concurrent assertions on the control block, bound into every pmod_ctrl.
// Covers the Wishbone ack rules and the calibration pipeline latency.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module pmod_asserts (
    input logic              clk,
    input logic              rst_n,
    input pmod_pkg::wb_req_t wb_req,
    input pmod_pkg::wb_rsp_t wb_rsp,
    input logic              cal_issue,
    input logic              cal_valid
);

    int fail_count = 0;

    // ack belongs to the cycle after stb rises and lasts one cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_req.stb) && wb_req.cyc |=> wb_rsp.ack ##1 !wb_rsp.ack)
        else begin
            fail_count++;
            $error("ack did not come for exactly one cycle after stb rose");
        end

    ack_with_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fail_count++;
            $error("ack raised without cyc and stb");
        end

    // Pipeline depth of sample_cal
    cal_latency: assert property (@(posedge clk) disable iff (!rst_n)
        cal_issue |-> ##2 cal_valid)
        else begin
            fail_count++;
            $error("cal_valid did not follow cal_issue after two cycles");
        end

endmodule

bind pmod_ctrl pmod_asserts asserts0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cal_issue (cal_issue),
    .cal_valid (cal_valid)
);

//--- test/pmod_checker.sv
// ---------------------------------------------------------------------------
// Checker for the codec subsystem. Deserializes sdin1 on bick, checks the
// lrck slot pattern and compares each DAC frame and each bus read with the
// expected values handed over by the testbench, keeping the error counts.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module pmod_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              bick,
    input logic              lrck,
    input logic              sdin1,
    input pmod_pkg::wb_rsp_t wb_rsp
);
    import pmod_pkg::*;

    localparam int FRAME_BITS = 4 * SLOT_BITS;

    logic [FRAME_BITS-1:0] rx_frame;
    int                    bit_cnt = 0;
    int                    out_period = 0;
    int                    exp_period [$];
    sample_quad_t          exp_quad [$];
    string                 exp_name [$];
    int                    exp_count = 0;
    bit                    read_pending = 1'b0;
    string                 read_name;
    logic [31:0]           read_exp;
    int                    compares = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;

    task automatic expect_frame(input string name, input int per, input sample_quad_t q);
        exp_name.push_back(name);
        exp_period.push_back(per);
        exp_quad.push_back(q);
        exp_count++;
    endtask

    task automatic expect_read(input string name, input logic [31:0] data);
        read_name    = name;
        read_exp     = data;
        read_pending = 1'b1;
    endtask

    task automatic drop_read();
        read_pending = 1'b0;
    endtask

    task automatic note_failure(input string what);
        $display("Failure: %s", what);
        other_errors++;
    endtask

    task automatic compare_sample(input string name, input string field,
                                  input sample_t exp_v, input sample_t act_v);
        compares++;
        if (exp_v !== act_v) begin
            $display("[ERROR] %s %s: expected %h, actual %h", name, field, exp_v, act_v);
            value_errors++;
        end
    endtask

    task automatic check_lrck(input logic exp_v);
        compares++;
        if (lrck !== exp_v) begin
            $display("[ERROR] lrck at frame bit %0d: expected %b, actual %b",
                     bit_cnt, exp_v, lrck);
            value_errors++;
        end
    endtask

    task automatic check_frame();
        sample_quad_t act;
        sample_quad_t exp_q;
        string        name;
        act.ch0 = rx_frame[FRAME_BITS-1 -: SAMPLE_W];
        act.ch1 = rx_frame[FRAME_BITS-1-SLOT_BITS -: SAMPLE_W];
        act.ch2 = rx_frame[FRAME_BITS-1-2*SLOT_BITS -: SAMPLE_W];
        act.ch3 = rx_frame[FRAME_BITS-1-3*SLOT_BITS -: SAMPLE_W];
        while (exp_count > 0 && exp_period[0] < out_period) begin
            note_failure({"frame ", exp_name[0], " was never compared"});
            void'(exp_period.pop_front());
            void'(exp_quad.pop_front());
            void'(exp_name.pop_front());
            exp_count--;
        end
        if (exp_count > 0 && exp_period[0] == out_period) begin
            exp_q = exp_quad.pop_front();
            name  = exp_name.pop_front();
            void'(exp_period.pop_front());
            compare_sample(name, "ch0", exp_q.ch0, act.ch0);
            compare_sample(name, "ch1", exp_q.ch1, act.ch1);
            compare_sample(name, "ch2", exp_q.ch2, act.ch2);
            compare_sample(name, "ch3", exp_q.ch3, act.ch3);
            exp_count--;
        end
    endtask

    // sdin1 only moves on the falling bick edge
    always @(posedge bick) begin
        rx_frame = {rx_frame[FRAME_BITS-2:0], sdin1};
        bit_cnt++;
        if (bit_cnt == FRAME_BITS) begin
            bit_cnt = 0;
            check_frame();
            out_period++;
        end
    end

    // While bick is high, bit_cnt already counts the bit taken at its rise,
    // so lrck is high for counts 1 to 64 (slots 0 and 1)
    always @(negedge clk) begin
        if (rst_n && bick) begin
            check_lrck(bit_cnt >= 1 && bit_cnt <= 2 * SLOT_BITS);
        end
    end

    // Read data is stable in the middle of the ack cycle
    always @(negedge clk) begin
        if (rst_n && wb_rsp.ack && read_pending) begin
            compares++;
            if (wb_rsp.dat !== read_exp) begin
                $display("[ERROR] %s read: expected %h, actual %h",
                         read_name, read_exp, wb_rsp.dat);
                value_errors++;
            end
            read_pending = 1'b0;
        end
    end

endmodule

//--- test/pmod_vectors.txt
# W name addr data | R name addr expected | F name adc0..adc3 dac0..dac3 (hex)
# A frame's DAC values are the processed ADC values; writes apply to later frames
R rst_cal0 0 40000000
R rst_cal7 7 40000000
R rst_ctrl 8 00000000
F mirror_a 0000 1234 8000 7fff ffff edcb 7fff 8000
F mirror_b 00ff ff00 5555 aaaa ff00 00ff aaaa 5555
W cal0 0 40000100
W cal1 1 80000000
W cal2 2 20000000
W cal4 4 4000ff00
F cal_a 00ff 8000 0fff 1234 ff00 7fff f800 edcb
F cal_b 0000 7fff 0001 0000 ffff 8000 ffff ffff
R rd_cal0 0 40000100
R rd_cal1 1 80000000
R rd_cal2 2 20000000
R rd_cal4 4 4000ff00
W id_cal0 0 40000000
W id_cal1 1 40000000
W id_cal2 2 40000000
W id_cal4 4 40000000
W vca 8 00000001
F vca_a dfff 1fff 8000 bfff 1000 f000 3fff 4000
W crush 8 00000012
R rd_ctrl 8 00000012
F crush_a 1234 00ff fffe 8000 edc0 ff00 0000 7ff0
W mute 8 00000003
F mute_a 1234 5678 9abc def0 0000 0000 0000 0000

//--- test/tb_pmod.sv
// ---------------------------------------------------------------------------
// Testbench for the codec subsystem. Reads register accesses and ADC frames
// from the vector file, plays the codec side of the TDM link and drives the
// Wishbone bus. Output frames and read data are judged by pmod_checker.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_pmod;
    import pmod_pkg::*;

    localparam int    CLK_NS    = 100;
    localparam int    ACK_LIMIT = 16;
    localparam string VEC_FILE  = "test/pmod_vectors.txt";

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    bick;
    logic    lrck;
    logic    sdin1;
    logic    sdout1;

    // tb_cnt mirrors the frame position of the DUT
    logic [7:0]   tb_cnt;
    int           period;
    int           last_period;
    int           frames_started;
    int           frames_queued;
    sample_quad_t adc_frame;
    sample_quad_t adc_pending [$];
    sample_quad_t dac_pending [$];
    string        name_pending [$];

    string lines [$];
    int    n_lines;
    bit    loaded;

    pmod_top #(
        .SAMPLE_W (SAMPLE_W)
    ) dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .bick   (bick),
        .lrck   (lrck),
        .sdin1  (sdin1),
        .sdout1 (sdout1)
    );

    pmod_checker checker0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .bick   (bick),
        .lrck   (lrck),
        .sdin1  (sdin1),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    // A new ADC frame starts when the frame counter wraps
    task automatic start_frame();
        if (adc_pending.size() > 0) begin
            adc_frame = adc_pending.pop_front();
            // Two frame boundaries lie between ADC capture and DAC output
            checker0.expect_frame(name_pending.pop_front(), period + 2,
                                  dac_pending.pop_front());
            last_period = period;
            frames_started++;
        end else begin
            adc_frame = '0;
        end
    endtask

    // Bits change on the falling bick edge and go MSB first with zero low slot bits
    task automatic drive_bit();
        logic [4:0] bit_pos;
        sample_t    word;
        if (!tb_cnt[0]) begin
            bit_pos = tb_cnt[5:1];
            case (tb_cnt[7:6])
                2'd0:    word = adc_frame.ch0;
                2'd1:    word = adc_frame.ch1;
                2'd2:    word = adc_frame.ch2;
                default: word = adc_frame.ch3;
            endcase
            sdout1 = (bit_pos < 5'd16) ? word[4'd15 - bit_pos[3:0]] : 1'b0;
        end
    endtask

    initial begin : codec_model
        bit run;
        sdout1         = 1'b0;
        tb_cnt         = '0;
        period         = 0;
        last_period    = 0;
        frames_started = 0;
        adc_frame      = '0;
        forever begin
            @(posedge clk);
            run = rst_n;
            #5;
            if (run) begin
                tb_cnt = tb_cnt + 8'd1;
                if (tb_cnt == 8'd0) begin
                    period++;
                    start_frame();
                end
            end
            drive_bit();
        end
    end

    task automatic read_vectors();
        int    fd;
        string text;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            checker0.note_failure("cannot open the vector file");
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text[0] != "#") begin
                lines.push_back(text);
            end
        end
        $fclose(fd);
        n_lines = lines.size();
        loaded  = 1'b1;
    endtask

    // The request is held through the edge that sees ack
    task automatic bus_access(input string name, input logic wr, input logic [3:0] addr,
                              input logic [31:0] data);
        int waited;
        bit acked;
        @(posedge clk);
        #5;
        if (!wr) begin
            checker0.expect_read(name, data);
        end
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = wr;
        wb_req.adr = addr;
        wb_req.dat = wr ? data : '0;
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < ACK_LIMIT) begin
            @(posedge clk);
            #5;
            acked = wb_rsp.ack;
            waited++;
        end
        if (acked) begin
            @(posedge clk);
            #5;
        end else begin
            checker0.drop_read();
            checker0.note_failure({"no ack from the slave for access ", name});
        end
        wb_req = '0;
    endtask

    task automatic send_frame(input string name, input sample_quad_t adc,
                              input sample_quad_t dac);
        int idx;
        idx = frames_queued;
        adc_pending.push_back(adc);
        dac_pending.push_back(dac);
        name_pending.push_back(name);
        frames_queued++;
        wait (frames_started > idx);
        // Let the frame end so later writes land after its frame_strobe
        wait (period > last_period);
    endtask

    task automatic run_vectors();
        string       kind;
        string       name;
        int          n;
        logic [31:0] addr;
        logic [31:0] data;
        logic [15:0] a0, a1, a2, a3;
        logic [15:0] d0, d1, d2, d3;
        foreach (lines[i]) begin
            n = $sscanf(lines[i], "%s %s", kind, name);
            if (kind == "W" || kind == "R") begin
                n = $sscanf(lines[i], "%s %s %h %h", kind, name, addr, data);
                if (n != 4) begin
                    checker0.note_failure({"malformed bus line: ", lines[i]});
                end else begin
                    bus_access(name, kind == "W", addr[3:0], data);
                end
            end else if (kind == "F") begin
                n = $sscanf(lines[i], "%s %s %h %h %h %h %h %h %h %h", kind, name,
                            a0, a1, a2, a3, d0, d1, d2, d3);
                if (n != 10) begin
                    checker0.note_failure({"malformed frame line: ", lines[i]});
                end else begin
                    send_frame(name, {a0, a1, a2, a3}, {d0, d1, d2, d3});
                end
            end else begin
                checker0.note_failure({"unknown vector line: ", lines[i]});
            end
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        wb_req        = '0;
        loaded        = 1'b0;
        n_lines       = 0;
        frames_queued = 0;
        read_vectors();
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        run_vectors();
        wait (checker0.exp_count == 0);
        repeat (2) @(posedge clk);
        $display("Errors: %0d value, %0d other, %0d assertion, over %0d compares",
                 checker0.value_errors, checker0.other_errors,
                 dut0.pmod_ctrl_instance.asserts0.fail_count, checker0.compares);
        if (checker0.value_errors + checker0.other_errors
            + dut0.pmod_ctrl_instance.asserts0.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Each vector line costs at most about one frame, plus a fixed margin
    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(n_lines + 20) * FRAME_CLKS * CLK_NS;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the expected DAC frames never came",
                 limit_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
